// ==== qk7_console.f ====
source/board_pkg.sv
source/console_pkg.sv
source/sys_timebase.sv
source/button_toggle.sv
source/uart_rx.sv
source/uart_tx.sv
source/console_echo.sv
source/qk7_top.sv
tests/qk7_assertions.sv
tests/qk7_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := qk7_tb
FILELIST  := qk7_console.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "result: fail"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "result: no pass line"; exit 1; fi
	@echo "result: pass"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/qk7_tb.sv ====
// qk7 console testbench: uart frame driver and monitor, directed tests of timebase, echo, buttons
`timescale 1ns/1ps

module qk7_tb import console_pkg::*; ();

   localparam int BAUD_DIV = 8;
   localparam int TMO      = 400;   // cycles allowed per wait loop

   logic       sys_clk_p;
   logic       rst_n;
   logic [1:0] qk7_button;     // active low
   logic       qk7_uart_rxd;
   logic       qk7_uart_txd;
   logic [1:0] qk7_led;
   logic [1:0] qk7_gpio1;      // {ms, us}
   integer     seed;
   logic       upcase_mode;    // expected state of the case button

   qk7_top #(
      .CLK_PER_US (4),
      .US_PER_MS  (5),
      .DEBOUNCE_MS(3),
      .HEART_MS   (2),
      .BAUD_DIV   (BAUD_DIV)
   ) dut0 (.*);

   always #2 sys_clk_p = ~sys_clk_p;   // 4 ns period

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_value(input string name, input int expv, input int actv);
      assert (expv == actv)
      else stop_on_error($sformatf("[FAIL] %s: expected %0h, actual %0h", name, expv, actv));
   endtask

   task automatic drive_slot();   // 1 ns past the rising edge
      @(posedge sys_clk_p);
      #1;
   endtask

   // counts ms pulses at falling edges
   task automatic wait_ms(input int n);
      int seen;
      int cyc;
      seen = 0;
      cyc  = 0;
      while (seen < n) begin
         @(negedge sys_clk_p);
         cyc++;
         if (qk7_gpio1[1])
            seen++;
         if (cyc > n * 40)
            stop_on_error("timeout: no ms strobe on gpio1[1]");
      end
   endtask

   task automatic send_frame(input logic [7:0] dat, input logic stop);
      logic [9:0] bits;
      bits = {stop, dat, 1'b0};   // start bit first and data lsb first
      for (int i = 0; i < 10; i++) begin
         drive_slot();
         qk7_uart_rxd = bits[i];
         repeat (BAUD_DIV - 1) @(posedge sys_clk_p);
      end
      drive_slot();
      qk7_uart_rxd = 1'b1;   // idle
   endtask

   // waits for a start bit and samples every bit at its centre
   task automatic recv_frame(output logic [7:0] dat, output logic stop);
      int cyc;
      cyc = 0;
      do begin
         @(negedge sys_clk_p);
         cyc++;
         if (cyc > TMO)
            stop_on_error("timeout: no start bit on uart txd");
      end while (qk7_uart_txd);
      repeat (BAUD_DIV / 2) @(negedge sys_clk_p);
      if (qk7_uart_txd)
         stop_on_error("start bit on uart txd ended before its centre");
      for (int i = 0; i < 8; i++) begin
         repeat (BAUD_DIV) @(negedge sys_clk_p);
         dat[i] = qk7_uart_txd;
      end
      repeat (BAUD_DIV) @(negedge sys_clk_p);
      stop = qk7_uart_txd;
   endtask

   function automatic logic [7:0] expected_echo(input logic [7:0] b);
      if (upcase_mode && b >= CHAR_LOWER_A && b <= CHAR_LOWER_Z)
         return b - CASE_OFFSET;   // fold to upper case
      return b;
   endfunction

   task automatic echo_byte(input string name, input logic [7:0] dat);
      logic [7:0] got;
      logic       stop;
      fork
         send_frame(dat, 1'b1);
         recv_frame(got, stop);
      join
      compare_value(name, int'(expected_echo(dat)), int'(got));
      compare_value({name, " stop bit"}, 1, int'(stop));
   endtask

   // press right after an ms pulse and hold for n ms samples
   task automatic press_button(input int idx, input int n_ms);
      wait_ms(1);
      drive_slot();
      qk7_button[idx] = 1'b0;
      wait_ms(n_ms);
      drive_slot();
      qk7_button[idx] = 1'b1;
   endtask

   task automatic toggle_button(input int idx);
      press_button(idx, 5);
      wait_ms(4);   // release side re-arms after 3 samples
   endtask

   task automatic count_ms_to_flip(output int ms_seen);
      logic prev;
      int   cyc;
      prev    = qk7_led[0];
      ms_seen = 0;
      cyc     = 0;
      do begin
         @(negedge sys_clk_p);
         cyc++;
         if (qk7_gpio1[1])
            ms_seen++;
         if (cyc > TMO)
            stop_on_error("timeout: heartbeat led never inverted");
      end while (qk7_led[0] == prev);
   endtask

   task automatic check_reset_state();
      int gap;
      compare_value("reset_state led", 0, int'(qk7_led));
      compare_value("reset_state txd", 1, int'(qk7_uart_txd));
      wait_ms(1);   // align so this us pulse is index 0
      for (int k = 1; k <= 20; k++) begin
         gap = 0;
         do begin
            @(negedge sys_clk_p);
            gap++;
         end while (!qk7_gpio1[0] && gap < 10);
         compare_value("reset_state us gap", 4, gap);
         compare_value("reset_state ms", int'(k % 5 == 0), int'(qk7_gpio1[1]));
      end
   endtask

   task automatic echo_random_bytes();
      logic [31:0] rnd;
      upcase_mode = 1'b0;
      for (int i = 0; i < 16; i++) begin
         rnd = $random(seed);
         echo_byte("echo_plain", rnd[7:0]);
      end
   endtask

   task automatic debounce_case_button();
      press_button(1, 2);   // too short
      wait_ms(4);
      compare_value("button_debounce short press", 0, int'(qk7_led[1]));
      press_button(1, 8);   // flips on sample 3 and stays while held
      compare_value("button_debounce long press", 1, int'(qk7_led[1]));
      wait_ms(4);
      compare_value("button_debounce after release", 1, int'(qk7_led[1]));
      press_button(1, 5);
      compare_value("button_debounce second press", 0, int'(qk7_led[1]));
      wait_ms(4);
   endtask

   task automatic echo_folded_case();
      logic [7:0] chars [10];
      chars = '{8'h61, 8'h6d, 8'h7a, 8'h71, 8'h30, 8'h39, 8'h41, 8'h5a, 8'h7b, 8'h60};
      toggle_button(1);
      compare_value("echo_upcase mode led", 1, int'(qk7_led[1]));
      upcase_mode = 1'b1;
      foreach (chars[i])
         echo_byte("echo_upcase", chars[i]);
   endtask

   task automatic blink_heartbeat();
      int n_ms;
      int seen;
      int cyc;
      toggle_button(0);
      count_ms_to_flip(n_ms);   // syncs to an inversion, interval not checked
      for (int i = 0; i < 3; i++) begin
         count_ms_to_flip(n_ms);
         compare_value("heartbeat ms per inversion", 2, n_ms);
      end
      toggle_button(0);
      seen = 0;
      cyc  = 0;
      while (seen < 10) begin
         @(negedge sys_clk_p);
         compare_value("heartbeat held off", 0, int'(qk7_led[0]));
         if (qk7_gpio1[1])
            seen++;
         cyc++;
         if (cyc > TMO)
            stop_on_error("timeout: ms strobes stopped while heartbeat off");
      end
   endtask

   task automatic reject_bad_stop();
      fork
         send_frame(8'h55, 1'b0);   // framing error
         for (int i = 0; i < 30 * BAUD_DIV; i++) begin
            @(negedge sys_clk_p);
            compare_value("bad_stop_bit txd idle", 1, int'(qk7_uart_txd));
         end
      join
      echo_byte("bad_stop_bit recovery", 8'h6b);
   endtask

   initial begin
      seed         = 32'h745;
      sys_clk_p    = 1'b0;
      rst_n        = 1'b0;
      qk7_button   = 2'b11;   // released
      qk7_uart_rxd = 1'b1;
      upcase_mode  = 1'b0;
      repeat (10) @(posedge sys_clk_p);
      #1;
      rst_n = 1'b1;
      @(negedge sys_clk_p);
      check_reset_state();
      echo_random_bytes();
      debounce_case_button();
      echo_folded_case();
      blink_heartbeat();
      reject_bad_stop();
      if (dut0.chk0.fail_cnt == 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         stop_on_error("bound checks on strobes or serial line failed");
      end
   end

endmodule : qk7_tb

// ==== tests/qk7_assertions.sv ====
// qk7 bound checks: one-cycle strobes, ms only with us, serial line high while idle
`timescale 1ns/1ps

module qk7_assertions (
   input logic       sys_clk_p,
   input logic       rst_n,
   input logic [1:0] qk7_gpio1,      // {ms, us}
   input logic       qk7_uart_txd,
   input logic       tx_busy
);

   int unsigned fail_cnt = 0;   // assertion failures so far

   us_one_cycle: assert property (@(posedge sys_clk_p) disable iff (!rst_n)
      qk7_gpio1[0] |=> !qk7_gpio1[0])
      else begin
         $error("us strobe high for more than one cycle");
         fail_cnt++;
      end

   ms_one_cycle: assert property (@(posedge sys_clk_p) disable iff (!rst_n)
      qk7_gpio1[1] |=> !qk7_gpio1[1])
      else begin
         $error("ms strobe high for more than one cycle");
         fail_cnt++;
      end

   ms_with_us: assert property (@(posedge sys_clk_p) disable iff (!rst_n)
      qk7_gpio1[1] |-> qk7_gpio1[0])
      else begin
         $error("ms strobe without us strobe");
         fail_cnt++;
      end

   // line idles high and the last cycle before idle is the high stop bit
   txd_idle_high: assert property (@(posedge sys_clk_p) disable iff (!rst_n)
      !tx_busy |-> qk7_uart_txd && $past(qk7_uart_txd))
      else begin
         $error("uart txd low while transmitter idle or at end of stop bit");
         fail_cnt++;
      end

endmodule : qk7_assertions

bind qk7_top qk7_assertions chk0 (
   .sys_clk_p    (sys_clk_p),
   .rst_n        (rst_n),
   .qk7_gpio1    (qk7_gpio1),
   .qk7_uart_txd (qk7_uart_txd),
   .tx_busy      (tx_busy)
);

// ==== source/qk7_top.sv ====
// qk7 board top: timebase, debounced buttons, serial echo console and status leds
`timescale 1ns/1ps

module qk7_top import board_pkg::*, console_pkg::*; #(
   parameter int CLK_PER_US  = DEF_CLK_PER_US,
   parameter int US_PER_MS   = DEF_US_PER_MS,
   parameter int DEBOUNCE_MS = DEF_DEBOUNCE_MS,
   parameter int HEART_MS    = DEF_HEART_MS,
   parameter int BAUD_DIV    = DEF_BAUD_DIV
) (
   input  logic       sys_clk_p,      // system clock
   input  logic       rst_n,          // sync reset, active low
   input  logic [1:0] qk7_button,     // push buttons, active low
   input  logic       qk7_uart_rxd,   // serial in
   output logic       qk7_uart_txd,   // serial out
   output logic [1:0] qk7_led,        // 0 - heartbeat, 1 - upper case mode
   output logic [1:0] qk7_gpio1       // 0 - us strobe, 1 - ms strobe
);

   timebase_t tb;           // us/ms enables
   tty_t      rx_byte;      // received byte
   tty_t      tx_byte;      // byte to send
   logic      tx_busy;
   logic      timer_ena;    // button 0 state
   logic      upcase_ena;   // button 1 state
   logic      heartbeat;

   sys_timebase #(
      .CLK_PER_US (CLK_PER_US),
      .US_PER_MS  (US_PER_MS)
   ) timebase0 (
      .sys_clk_p (sys_clk_p),
      .rst_n     (rst_n),
      .tb        (tb)
   );

   button_toggle #(.DEBOUNCE_MS(DEBOUNCE_MS)) tog_timer (
      .sys_clk_p (sys_clk_p),
      .rst_n     (rst_n),
      .but_n     (qk7_button[0]),
      .tb        (tb),
      .toggle    (timer_ena)
   );

   button_toggle #(.DEBOUNCE_MS(DEBOUNCE_MS)) tog_case (
      .sys_clk_p (sys_clk_p),
      .rst_n     (rst_n),
      .but_n     (qk7_button[1]),
      .tb        (tb),
      .toggle    (upcase_ena)
   );

   uart_rx #(.BAUD_DIV(BAUD_DIV)) rx0 (
      .sys_clk_p (sys_clk_p),
      .rst_n     (rst_n),
      .rxd       (qk7_uart_rxd),
      .rx_byte   (rx_byte)
   );

   uart_tx #(.BAUD_DIV(BAUD_DIV)) tx0 (
      .sys_clk_p (sys_clk_p),
      .rst_n     (rst_n),
      .tx_byte   (tx_byte),
      .txd       (qk7_uart_txd),
      .tx_busy   (tx_busy)
   );

   console_echo #(.HEART_MS(HEART_MS)) console0 (
      .sys_clk_p  (sys_clk_p),
      .rst_n      (rst_n),
      .tb         (tb),
      .rx_byte    (rx_byte),
      .tx_busy    (tx_busy),
      .timer_ena  (timer_ena),
      .upcase_ena (upcase_ena),
      .tx_byte    (tx_byte),
      .heartbeat  (heartbeat)
   );

   assign qk7_led   = {upcase_ena, heartbeat};
   assign qk7_gpio1 = {tb.ms, tb.us};   // strobes out for the scope

endmodule : qk7_top

// ==== source/console_echo.sv ====
// console echo: optional upper-case folding, one-byte pending slot, heartbeat led
`timescale 1ns/1ps

module console_echo import board_pkg::*, console_pkg::*; #(
   parameter int HEART_MS = 500
) (
   input  logic      sys_clk_p,
   input  logic      rst_n,
   input  timebase_t tb,
   input  tty_t      rx_byte,
   input  logic      tx_busy,
   input  logic      timer_ena,
   input  logic      upcase_ena,
   output tty_t      tx_byte,
   output logic      heartbeat
);

   localparam int HW = (HEART_MS > 1) ? $clog2(HEART_MS) : 1;
   localparam logic [HW-1:0] HB_LAST = HW'(HEART_MS - 1);

   logic [7:0]    folded;     // rx byte after case folding
   logic          is_lower;
   logic          pend_full;  // slot holds a byte
   logic [7:0]    pend_dat;
   logic          send;       // slot goes to the transmitter this cycle
   logic          tx_stb;
   logic [7:0]    tx_dat;
   logic [HW-1:0] hb_cnt;     // ms strobes since last inversion

   assign is_lower = (rx_byte.dat >= CHAR_LOWER_A) && (rx_byte.dat <= CHAR_LOWER_Z);
   assign folded   = (upcase_ena && is_lower) ? rx_byte.dat - CASE_OFFSET : rx_byte.dat;

   // tx_stb guard covers the cycle before busy rises
   assign send    = pend_full && !tx_busy && !tx_stb;
   assign tx_byte = '{stb: tx_stb, dat: tx_dat};

   always_ff @(posedge sys_clk_p) begin
      if (!rst_n) begin
         pend_full <= 1'b0;
         tx_stb    <= 1'b0;
      end else begin
         tx_stb <= send;
         if (rx_byte.stb && (!pend_full || send))
            pend_full <= 1'b1;   // new byte dropped while the slot stays full
         else if (send)
            pend_full <= 1'b0;
      end
   end

   // slot and transmit data
   always_ff @(posedge sys_clk_p) begin
      if (rx_byte.stb && (!pend_full || send))
         pend_dat <= folded;
      if (send)
         tx_dat <= pend_dat;
   end

   // heartbeat held off and cleared while the timer button is off
   always_ff @(posedge sys_clk_p) begin
      if (!rst_n || !timer_ena) begin
         hb_cnt    <= '0;
         heartbeat <= 1'b0;
      end else if (tb.ms) begin
         if (hb_cnt == HB_LAST) begin
            hb_cnt    <= '0;
            heartbeat <= ~heartbeat;
         end else begin
            hb_cnt <= hb_cnt + 1'b1;
         end
      end
   end

endmodule : console_echo

// ==== source/uart_tx.sv ====
// uart transmitter: 8N1 frame shifter with busy level, line high while idle
`timescale 1ns/1ps

module uart_tx import console_pkg::*; #(
   parameter int BAUD_DIV = 434
) (
   input  logic sys_clk_p,
   input  logic rst_n,
   input  tty_t tx_byte,
   output logic txd,
   output logic tx_busy
);

   localparam int BW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
   localparam logic [BW-1:0] BIT_LAST = BW'(BAUD_DIV - 1);

   logic [9:0]    frame;      // stop, data[7:0], start; bit 0 on the line
   logic [BW-1:0] baud_cnt;   // clocks left in current bit
   logic [3:0]    bits_left;  // bits after the current one

   // idle line high, otherwise the current frame bit
   assign txd = ~tx_busy | frame[0];

   always_ff @(posedge sys_clk_p) begin
      if (!rst_n) begin
         tx_busy   <= 1'b0;
         baud_cnt  <= '0;
         bits_left <= '0;
      end else if (!tx_busy) begin
         if (tx_byte.stb) begin
            tx_busy   <= 1'b1;
            baud_cnt  <= BIT_LAST;
            bits_left <= 4'd9;
         end
      end else if (baud_cnt != '0) begin
         baud_cnt <= baud_cnt - 1'b1;
      end else if (bits_left == '0) begin
         tx_busy <= 1'b0;   // end of stop bit
      end else begin
         baud_cnt  <= BIT_LAST;
         bits_left <= bits_left - 1'b1;
      end
   end

   // frame loaded on start and shifted once per bit
   always_ff @(posedge sys_clk_p) begin
      if (!tx_busy && tx_byte.stb)
         frame <= {1'b1, tx_byte.dat, 1'b0};
      else if (tx_busy && baud_cnt == '0)
         frame <= {1'b1, frame[9:1]};   // ones shift in behind the stop bit
   end

endmodule : uart_tx

// ==== source/uart_rx.sv ====
// uart receiver: 8N1, start edge detect, centre sampling, stop bit check before strobe
`timescale 1ns/1ps

module uart_rx import console_pkg::*; #(
   parameter int BAUD_DIV = 434
) (
   input  logic sys_clk_p,
   input  logic rst_n,
   input  logic rxd,
   output tty_t rx_byte
);

   localparam int BW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
   localparam logic [BW-1:0] BIT_LAST  = BW'(BAUD_DIV - 1);
   localparam logic [BW-1:0] HALF_LAST = BW'(BAUD_DIV / 2 - 1);   // to start bit centre

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_START = 2'd1;
   localparam logic [1:0] ST_DATA  = 2'd2;
   localparam logic [1:0] ST_STOP  = 2'd3;

   logic [1:0]    rxd_sync;   // synchronizer
   logic          rxd_d;      // previous synced sample, for edge detect
   logic          rxd_s;
   logic [1:0]    state;
   logic [BW-1:0] baud_cnt;   // clocks to next sample point
   logic [2:0]    bit_idx;    // data bit being received
   logic [7:0]    shreg;      // lsb first, enters at the top
   logic          rx_stb;

   assign rxd_s   = rxd_sync[1];
   assign rx_byte = '{stb: rx_stb, dat: shreg};   // shreg stable after the stop bit

   always_ff @(posedge sys_clk_p) begin
      if (!rst_n) begin
         rxd_sync <= 2'b11;   // line idles high
         rxd_d    <= 1'b1;
         state    <= ST_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
         rx_stb   <= 1'b0;
      end else begin
         rxd_sync <= {rxd_sync[0], rxd};
         rxd_d    <= rxd_s;
         rx_stb   <= 1'b0;

         if (state != ST_IDLE)
            baud_cnt <= (baud_cnt == '0) ? BIT_LAST : baud_cnt - 1'b1;

         case (state)
            ST_IDLE: begin
               if (rxd_d && !rxd_s) begin   // falling edge, start bit
                  baud_cnt <= HALF_LAST;
                  state    <= ST_START;
               end
            end
            ST_START: begin
               if (baud_cnt == '0) begin
                  bit_idx <= '0;
                  state   <= rxd_s ? ST_IDLE : ST_DATA;   // glitch if high again
               end
            end
            ST_DATA: begin
               if (baud_cnt == '0) begin
                  shreg   <= {rxd_s, shreg[7:1]};
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= ST_STOP;
               end
            end
            default: begin   // ST_STOP
               if (baud_cnt == '0) begin
                  rx_stb <= rxd_s;   // framing error gives nothing
                  state  <= ST_IDLE;
               end
            end
         endcase
      end
   end

endmodule : uart_rx

// ==== source/button_toggle.sv ====
// button toggle: synchronized, ms-sampled debounce, output flips once per press
`timescale 1ns/1ps

module button_toggle import board_pkg::*; #(
   parameter int DEBOUNCE_MS = 20
) (
   input  logic      sys_clk_p,
   input  logic      rst_n,
   input  logic      but_n,     // raw button, active low
   input  timebase_t tb,
   output logic      toggle
);

   localparam int CW = (DEBOUNCE_MS > 1) ? $clog2(DEBOUNCE_MS) : 1;
   localparam logic [CW-1:0] CNT_LAST = CW'(DEBOUNCE_MS - 1);

   logic [1:0]    but_sync;   // two-flop synchronizer, [1] is safe
   logic          pressed;
   logic          armed;      // 1 - waiting for press, 0 - waiting for release
   logic          match;      // sample agrees with what we wait for
   logic [CW-1:0] cnt;        // consecutive matching samples - 1

   assign pressed = ~but_sync[1];
   assign match   = armed ? pressed : ~pressed;

   always_ff @(posedge sys_clk_p) begin
      if (!rst_n) begin
         but_sync <= 2'b11;   // released
         armed    <= 1'b1;
         cnt      <= '0;
         toggle   <= 1'b0;
      end else begin
         but_sync <= {but_sync[0], but_n};

         if (tb.ms) begin
            if (!match) begin
               cnt <= '0;   // bounce, start over
            end else if (cnt == CNT_LAST) begin
               cnt   <= '0;
               armed <= ~armed;     // press disarms, release re-arms
               if (armed)
                  toggle <= ~toggle;   // only on the press side
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
      end
   end

endmodule : button_toggle

// ==== source/sys_timebase.sv ====
// system timebase: cascaded down-counters producing microsecond and millisecond enables
`timescale 1ns/1ps

module sys_timebase import board_pkg::*; #(
   parameter int CLK_PER_US = 50,
   parameter int US_PER_MS  = 1000
) (
   input  logic      sys_clk_p,
   input  logic      rst_n,
   output timebase_t tb
);

   localparam int UW = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;   // us counter width
   localparam int MW = (US_PER_MS > 1) ? $clog2(US_PER_MS) : 1;     // ms counter width

   localparam logic [UW-1:0] US_LAST = UW'(CLK_PER_US - 1);   // reload values
   localparam logic [MW-1:0] MS_LAST = MW'(US_PER_MS - 1);

   logic [UW-1:0] us_cnt;   // clocks left in this us
   logic [MW-1:0] ms_cnt;   // us strobes left in this ms
   logic          us_wrap;  // us counter expires this cycle

   assign us_wrap = (us_cnt == '0);

   always_ff @(posedge sys_clk_p) begin
      if (!rst_n) begin
         us_cnt <= US_LAST;   // first strobe CLK_PER_US cycles out
         ms_cnt <= MS_LAST;
         tb     <= '0;
      end else begin
         tb.us <= us_wrap;
         tb.ms <= us_wrap && (ms_cnt == '0);   // rides on the us pulse only

         if (us_wrap) begin
            us_cnt <= US_LAST;
            // ms counter advances once per us
            if (ms_cnt == '0)
               ms_cnt <= MS_LAST;
            else
               ms_cnt <= ms_cnt - 1'b1;
         end else begin
            us_cnt <= us_cnt - 1'b1;
         end
      end
   end

endmodule : sys_timebase

// ==== source/console_pkg.sv ====
// console data package: tty byte bundle and character constants for case folding
package console_pkg;

   // byte with its qualifying strobe, as moved between uart and echo
   typedef struct packed {
      logic       stb;   // one-cycle pulse, dat valid
      logic [7:0] dat;   // character code
   } tty_t;

   // lower-case ascii range
   localparam logic [7:0] CHAR_LOWER_A = 8'h61;   // 'a'
   localparam logic [7:0] CHAR_LOWER_Z = 8'h7a;   // 'z'

   // 'a' - 'A', subtract to fold
   localparam logic [7:0] CASE_OFFSET  = 8'h20;

endpackage : console_pkg

// ==== source/board_pkg.sv ====
// board timing package: strobe bundle and default clock/baud figures for the qk7 console
package board_pkg;

   // slow enables shared by every clock-enabled block
   typedef struct packed {
      logic us;   // one-cycle microsecond enable
      logic ms;   // one-cycle millisecond enable, only with us
   } timebase_t;

   // defaults for a 50 MHz board clock
   localparam int DEF_CLK_PER_US  = 50;       // sys clocks per microsecond
   localparam int DEF_US_PER_MS   = 1000;     // us strobes per ms strobe
   localparam int DEF_DEBOUNCE_MS = 20;       // stable samples before a button counts

   // heartbeat half period
   localparam int DEF_HEART_MS    = 500;      // ms strobes per led inversion

   // serial console at 115200 baud
   localparam int DEF_BAUD_DIV    = 434;      // 50e6 / 115200, rounded down

endpackage : board_pkg
